// ==== vliwCore.f ====
+incdir+hdl
hdl/vliwPkg.sv
hdl/bundleDecode.sv
hdl/widenedRegFile.sv
hdl/laneExecute.sv
hdl/vliwCore.sv
sim/vliwCore_assertions.sv
sim/vliwCore_tb.sv

// ==== sim/vliwCore_tb.sv ====
// Table rows issue back-to-back, so each row sees the results of the rows before
// Random section issues only ADDI bundles, checked against a reference register model
// Every bundle is checked two cycles after it is driven

`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_consts.svh"

module vliwCore_tb;

  localparam int numRandom = 40;  // Random bundles after the table

  logic clk = 1'b0;
  logic reset;
  logic bundleValid;
  logic [`VLIW_LANES-1:0]                laneValid;
  logic [`VLIW_LANES-1:0][`INSTR_W-1:0]  instr;
  logic [`VLIW_LANES-1:0]                wbValid;
  vliwPkg::regAddr_t [`VLIW_LANES-1:0]   wbRd;
  vliwPkg::word_t [`VLIW_LANES-1:0]      wbData;

  // Stimulus table, one entry per bundle
  logic [`VLIW_LANES-1:0]                rowMask[$];
  logic [`VLIW_LANES-1:0][`INSTR_W-1:0]  rowInstr[$];
  logic [`VLIW_LANES-1:0]                rowValid[$];
  vliwPkg::word_t [`VLIW_LANES-1:0]      rowData[$];

  // Expected results in flight
  logic [`VLIW_LANES-1:0]                pendValid[$];
  vliwPkg::regAddr_t [`VLIW_LANES-1:0]   pendRd[$];
  vliwPkg::word_t [`VLIW_LANES-1:0]      pendData[$];

  vliwPkg::word_t refRegs [`NUM_REGS];  // Architectural register model
  int cycleCount = 0;
  int cycleLimit;

  vliwCore uut (
    .clk, .reset, .bundleValid, .laneValid, .instr, .wbValid, .wbRd, .wbData);

  always #20 clk = ~clk;  // 40 ns period

  // Watchdog, also picks up bound assertion failures
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Run timed out after %0d cycles without finishing", cycleLimit);
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
    end else if (uut.checks.failCount != 0) begin
      $display("A concurrent assertion on the DUT outputs failed");
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // RV32I encoders and reference semantics
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encodeLui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Only ALU, ALU-immediate and LUI with a nonzero rd write back
  function automatic logic laneLegal(input logic [31:0] ins);
    logic [6:0] op;
    op = ins[6:0];
    return (op == vliwPkg::OpReg || op == vliwPkg::OpImm || op == vliwPkg::OpLui) &&
           ins[11:7] != 5'd0;
  endfunction

  function automatic logic [31:0] refResult(input logic [31:0] ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a  = refRegs[ins[19:15]];
    b  = (ins[6:0] == 7'b0010011) ? {{20{ins[31]}}, ins[31:20]} : refRegs[ins[24:20]];
    sh = b[4:0];  // Low five bits only
    if (ins[6:0] == 7'b0110111) return {ins[31:12], 12'h000};
    case (ins[14:12])
      3'd0: return (ins[6:0] == 7'b0110011 && ins[30]) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (ins[30]) return $signed(a) >>> sh;  // Arithmetic
        return a >> sh;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Issue one bundle, check the one driven two cycles earlier
  //////////////////////////////////////////////////////////////////////
  task automatic issueBundle(input logic bv, input logic [3:0] mask,
                             input logic [3:0][31:0] ins, input logic fromTable,
                             input logic [3:0] tValid, input vliwPkg::word_t [3:0] tData);
    logic [3:0]                mValid;
    logic [3:0]                v;
    vliwPkg::word_t [3:0]      mData;
    vliwPkg::word_t [3:0]      d;
    vliwPkg::regAddr_t [3:0]   rd;
    if (pendValid.size() == 2) begin
      v  = pendValid.pop_front();
      rd = pendRd.pop_front();
      d  = pendData.pop_front();
      checkValue("wbValid", 32'(v), 32'(wbValid));
      for (int l = 0; l < `VLIW_LANES; l++) begin
        if (v[l]) begin
          checkValue($sformatf("wbRd[%0d]", l), 32'(rd[l]), 32'(wbRd[l]));
          checkValue($sformatf("wbData[%0d]", l), d[l], wbData[l]);
        end
      end
    end
    bundleValid = bv;
    laneValid   = mask;
    instr       = ins;
    for (int l = 0; l < `VLIW_LANES; l++) begin
      mValid[l] = bv & mask[l] & laneLegal(ins[l]);
      mData[l]  = mValid[l] ? refResult(ins[l]) : '0;  // Pre-bundle state
      rd[l]     = ins[l][11:7];
    end
    for (int l = 0; l < `VLIW_LANES; l++) begin
      if (mValid[l]) refRegs[rd[l]] = mData[l];  // Higher lane written last
    end
    pendValid.push_back(fromTable ? tValid : mValid);
    pendRd.push_back(rd);
    pendData.push_back(fromTable ? tData : mData);
    @(posedge clk);
    #2;
  endtask

  task automatic addRow(input logic [3:0] mask, input logic [31:0] i0, i1, i2, i3,
                        input logic [3:0] valid, input logic [31:0] d0, d1, d2, d3);
    rowMask.push_back(mask);
    rowInstr.push_back({i3, i2, i1, i0});
    rowValid.push_back(valid);
    rowData.push_back({d3, d2, d1, d0});
  endtask

  task automatic loadTable();
    // Four independent ADDIs
    addRow(4'hf, encodeI(12'd5, 3'd0, 5'd1, 5'd0), encodeI(12'hffd, 3'd0, 5'd2, 5'd0),
      encodeI(12'h7ff, 3'd0, 5'd3, 5'd0), encodeI(12'h800, 3'd0, 5'd4, 5'd0),
      4'hf, 32'h5, 32'hffff_fffd, 32'h7ff, 32'hffff_f800);
    // ADD SUB SLT SLTU, all forwarded across lanes
    addRow(4'hf, encodeR(7'h00, 3'd0, 5'd5, 5'd1, 5'd2), encodeR(7'h20, 3'd0, 5'd6, 5'd2, 5'd1),
      encodeR(7'h00, 3'd2, 5'd7, 5'd2, 5'd1), encodeR(7'h00, 3'd3, 5'd8, 5'd2, 5'd1),
      4'hf, 32'h2, 32'hffff_fff8, 32'h1, 32'h0);
    // Shifts through write-first reads, XOR forwarded
    addRow(4'hf, encodeR(7'h20, 3'd5, 5'd9, 5'd4, 5'd1), encodeR(7'h00, 3'd5, 5'd10, 5'd4, 5'd1),
      encodeR(7'h00, 3'd1, 5'd11, 5'd3, 5'd1), encodeR(7'h00, 3'd4, 5'd12, 5'd5, 5'd6),
      4'hf, 32'hffff_ffc0, 32'h07ff_ffc0, 32'h0000_ffe0, 32'hffff_fffa);
    addRow(4'hf, encodeR(7'h00, 3'd6, 5'd13, 5'd1, 5'd3), encodeR(7'h00, 3'd7, 5'd14, 5'd2, 5'd4),
      encodeLui(20'h12345, 5'd15), encodeR(7'h00, 3'd2, 5'd16, 5'd1, 5'd2),
      4'hf, 32'h7ff, 32'hffff_f800, 32'h1234_5000, 32'h0);
    // Lanes 0 and 2 both write x1, lanes 1 and 3 read the old x1
    addRow(4'hf, encodeI(12'd100, 3'd0, 5'd1, 5'd0), encodeI(12'd1, 3'd0, 5'd17, 5'd1),
      encodeI(12'd200, 3'd0, 5'd1, 5'd0), encodeI(12'd0, 3'd0, 5'd18, 5'd1),
      4'hf, 32'd100, 32'd6, 32'd200, 32'd5);
    // Masked lane 2, ECALL in lane 3
    addRow(4'b1011, encodeR(7'h00, 3'd0, 5'd19, 5'd1, 5'd0), encodeI(12'd0, 3'd0, 5'd20, 5'd17),
      encodeI(12'd1, 3'd0, 5'd21, 5'd0), 32'h0000_0073,
      4'b0011, 32'd200, 32'd6, 32'h0, 32'h0);
    // rd of x0, then a store opcode
    addRow(4'hf, encodeI(12'd55, 3'd0, 5'd0, 5'd0), encodeR(7'h00, 3'd0, 5'd22, 5'd0, 5'd1),
      encodeR(7'h20, 3'd0, 5'd23, 5'd0, 5'd2), 32'h0020_a023,
      4'b0110, 32'h0, 32'd200, 32'd3, 32'h0);
    addRow(4'hf, encodeR(7'h00, 3'd0, 5'd24, 5'd0, 5'd0), encodeR(7'h00, 3'd0, 5'd25, 5'd1, 5'd0),
      encodeI(12'd0, 3'd0, 5'd26, 5'd21), encodeI(12'h401, 3'd5, 5'd27, 5'd2),
      4'hf, 32'h0, 32'd200, 32'h0, 32'hffff_fffe);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [3:0]       mask;
    logic [3:0][31:0] ins;
    void'($urandom(32'hfee2_6b77));
    reset       = 1'b1;
    bundleValid = 1'b0;
    laneValid   = '0;
    instr       = '0;
    for (int r = 0; r < `NUM_REGS; r++) refRegs[r] = '0;
    loadTable();
    cycleLimit = rowInstr.size() + numRandom + 10;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    foreach (rowInstr[i]) begin
      issueBundle(1'b1, rowMask[i], rowInstr[i], 1'b1, rowValid[i], rowData[i]);
    end
    // Random ADDI bundles, back to back
    for (int n = 0; n < numRandom; n++) begin
      mask = 4'($urandom());
      for (int l = 0; l < `VLIW_LANES; l++) begin
        ins[l] = encodeI(12'($urandom()), 3'd0, 5'($urandom()), 5'($urandom()));
      end
      issueBundle(($urandom() % 8) != 0, mask, ins, 1'b0, '0, '0);
    end
    repeat (2) issueBundle(1'b0, '0, '0, 1'b0, '0, '0);  // Drain the pipe
    if (uut.checks.failCount == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "%0d assertion failures", uut.checks.failCount);
    end
  end

endmodule

`default_nettype wire

// ==== sim/vliwCore_assertions.sv ====
// Bound into every vliwCore, watches only the top-level W-stage outputs
// Assumes the fixed issue-to-writeback latency and no writes to x0

`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_consts.svh"

module vliwCore_assertions (
  input logic                                  clk,
  input logic                                  reset,
  input logic                                  bundleValid,
  input logic [`VLIW_LANES-1:0]                laneValid,
  input logic [`VLIW_LANES-1:0][`INSTR_W-1:0]  instr,
  input logic [`VLIW_LANES-1:0]                wbValid,
  input vliwPkg::regAddr_t [`VLIW_LANES-1:0]   wbRd
);

  int failCount = 0;                // Bumped by every failing assertion
  logic [`VLIW_LANES-1:0] issued;   // Legal op with a real rd in this lane

  always_comb begin
    for (int l = 0; l < `VLIW_LANES; l++) begin
      issued[l] = bundleValid && laneValid[l] && instr[l][11:7] != 5'd0 &&
        (instr[l][6:0] == vliwPkg::OpReg || instr[l][6:0] == vliwPkg::OpImm ||
         instr[l][6:0] == vliwPkg::OpLui);
    end
  end

  // W stage comes out of reset empty
  resetClears: assert property (@(posedge clk) reset |=> wbValid == '0)
    else begin
      $error("wbValid set in the cycle after a reset edge");
      failCount++;
    end

  //////////////////////////////////////////////////////////////////////
  // Per-lane writeback rules
  //////////////////////////////////////////////////////////////////////
  for (genvar l = 0; l < `VLIW_LANES; l++) begin : laneChecks
    rdNonZero: assert property (@(posedge clk) disable iff (reset)
      wbValid[l] |-> wbRd[l] != 5'd0)
      else begin
        $error("Lane %0d writes back to x0", l);
        failCount++;
      end

    issueLatency: assert property (@(posedge clk) disable iff (reset)
      issued[l] |-> ##2 wbValid[l])
      else begin
        $error("Lane %0d missed its writeback two cycles after issue", l);
        failCount++;
      end

    // No writeback without a matching issue
    noSpurious: assert property (@(posedge clk) disable iff (reset)
      !issued[l] |-> ##2 !wbValid[l])
      else begin
        $error("Lane %0d wrote back with no legal issue", l);
        failCount++;
      end
  end

endmodule

bind vliwCore vliwCore_assertions checks (
  .clk, .reset, .bundleValid, .laneValid, .instr, .wbValid, .wbRd);

`default_nettype wire

// ==== hdl/vliwCore.sv ====
// Four-lane VLIW integer core top level
// Two-cycle fixed latency, no stall or back-pressure, a bundle may issue every cycle
// W-stage outputs double as regfile write ports and forwarding sources

`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_consts.svh"

module vliwCore (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  bundleValid,
  input  logic [`VLIW_LANES-1:0]                laneValid,
  input  logic [`VLIW_LANES-1:0][`INSTR_W-1:0]  instr,
  output logic [`VLIW_LANES-1:0]                wbValid,
  output vliwPkg::regAddr_t [`VLIW_LANES-1:0]   wbRd,
  output vliwPkg::word_t [`VLIW_LANES-1:0]      wbData
);

  vliwPkg::regAddr_t [2*`VLIW_LANES-1:0]  rdAddr;   // Two read ports per lane
  vliwPkg::word_t [2*`VLIW_LANES-1:0]     rdData;
  logic [`VLIW_LANES-1:0]                 exValid;
  logic [`VLIW_LANES-1:0]                 exUseImm;
  vliwPkg::aluOp_t [`VLIW_LANES-1:0]      exAluOp;
  vliwPkg::regAddr_t [`VLIW_LANES-1:0]    exRd;
  vliwPkg::regAddr_t [`VLIW_LANES-1:0]    exRs1;
  vliwPkg::regAddr_t [`VLIW_LANES-1:0]    exRs2;
  vliwPkg::word_t [`VLIW_LANES-1:0]       exSrcA;
  vliwPkg::word_t [`VLIW_LANES-1:0]       exSrcB;

  bundleDecode decode (
    .clk, .reset, .bundleValid, .laneValid, .instr, .rdData, .rdAddr,
    .exValid, .exAluOp, .exRd, .exRs1, .exRs2, .exSrcA, .exSrcB, .exUseImm);

  // Write ports fed straight from the W stage
  widenedRegFile regFile (
    .clk, .reset, .rdAddr, .rdData,
    .weValid(wbValid), .weAddr(wbRd), .weData(wbData));

  //////////////////////////////////////////////////////////////////////
  // Execute lanes, each sees every lane's W stage
  //////////////////////////////////////////////////////////////////////
  laneExecute lane0 (
    .clk, .reset, .exValid(exValid[0]), .exAluOp(exAluOp[0]), .exRd(exRd[0]),
    .exRs1(exRs1[0]), .exRs2(exRs2[0]), .exSrcA(exSrcA[0]), .exSrcB(exSrcB[0]),
    .exUseImm(exUseImm[0]), .fwdValid(wbValid), .fwdRd(wbRd), .fwdData(wbData),
    .wbValid(wbValid[0]), .wbRd(wbRd[0]), .wbData(wbData[0]));

  laneExecute lane1 (
    .clk, .reset, .exValid(exValid[1]), .exAluOp(exAluOp[1]), .exRd(exRd[1]),
    .exRs1(exRs1[1]), .exRs2(exRs2[1]), .exSrcA(exSrcA[1]), .exSrcB(exSrcB[1]),
    .exUseImm(exUseImm[1]), .fwdValid(wbValid), .fwdRd(wbRd), .fwdData(wbData),
    .wbValid(wbValid[1]), .wbRd(wbRd[1]), .wbData(wbData[1]));

  laneExecute lane2 (
    .clk, .reset, .exValid(exValid[2]), .exAluOp(exAluOp[2]), .exRd(exRd[2]),
    .exRs1(exRs1[2]), .exRs2(exRs2[2]), .exSrcA(exSrcA[2]), .exSrcB(exSrcB[2]),
    .exUseImm(exUseImm[2]), .fwdValid(wbValid), .fwdRd(wbRd), .fwdData(wbData),
    .wbValid(wbValid[2]), .wbRd(wbRd[2]), .wbData(wbData[2]));

  laneExecute lane3 (
    .clk, .reset, .exValid(exValid[3]), .exAluOp(exAluOp[3]), .exRd(exRd[3]),
    .exRs1(exRs1[3]), .exRs2(exRs2[3]), .exSrcA(exSrcA[3]), .exSrcB(exSrcB[3]),
    .exUseImm(exUseImm[3]), .fwdValid(wbValid), .fwdRd(wbRd), .fwdData(wbData),
    .wbValid(wbValid[3]), .wbRd(wbRd[3]), .wbData(wbData[3]));

endmodule

`default_nettype wire

// ==== hdl/laneExecute.sv ====
// One execute lane, forwarding from all lanes' W stage, ALU, W register
// Forwarding priority matches the register file, highest lane wins
// Immediate operand B is never replaced by a forwarded value

`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_consts.svh"

module laneExecute (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 exValid,
  input  vliwPkg::aluOp_t                      exAluOp,
  input  vliwPkg::regAddr_t                    exRd,
  input  vliwPkg::regAddr_t                    exRs1,
  input  vliwPkg::regAddr_t                    exRs2,
  input  vliwPkg::word_t                       exSrcA,
  input  vliwPkg::word_t                       exSrcB,
  input  logic                                 exUseImm,
  input  logic [`VLIW_LANES-1:0]               fwdValid,
  input  vliwPkg::regAddr_t [`VLIW_LANES-1:0]  fwdRd,
  input  vliwPkg::word_t [`VLIW_LANES-1:0]     fwdData,
  output logic                                 wbValid,
  output vliwPkg::regAddr_t                    wbRd,
  output vliwPkg::word_t                       wbData
);

  vliwPkg::word_t opA;        // Forwarded operand A
  vliwPkg::word_t opB;        // Forwarded operand B or immediate
  vliwPkg::word_t aluResult;
  logic [4:0]     shamt;

  //////////////////////////////////////////////////////////////////////
  // Cross-lane forwarding from the bundle ahead
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    opA = exSrcA;  // Value read at decode
    opB = exSrcB;
    for (int l = 0; l < `VLIW_LANES; l++) begin
      if (fwdValid[l] && fwdRd[l] != '0) begin
        if (fwdRd[l] == exRs1) begin
          opA = fwdData[l];
        end
        if (!exUseImm && fwdRd[l] == exRs2) begin
          opB = fwdData[l];
        end
      end
    end
  end

  assign shamt = opB[4:0];  // RV32 shifts use the low 5 bits

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (exAluOp)
      vliwPkg::AluAdd:   aluResult = opA + opB;
      vliwPkg::AluSub:   aluResult = opA - opB;
      vliwPkg::AluSll:   aluResult = opA << shamt;
      vliwPkg::AluSlt:   aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      vliwPkg::AluSltu:  aluResult = {{(`XLEN-1){1'b0}}, opA < opB};
      vliwPkg::AluXor:   aluResult = opA ^ opB;
      vliwPkg::AluSrl:   aluResult = opA >> shamt;
      vliwPkg::AluSra:   aluResult = $signed(opA) >>> shamt;  // Sign fill
      vliwPkg::AluOr:    aluResult = opA | opB;
      vliwPkg::AluAnd:   aluResult = opA & opB;
      vliwPkg::AluPassB: aluResult = opB;
      default:           aluResult = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // W-stage register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= exValid;
    end
  end

  always_ff @(posedge clk) begin
    wbRd   <= exRd;
    wbData <= aluResult;  // Held one cycle, feeds regfile and forwarding
  end

endmodule

`default_nettype wire

// ==== hdl/widenedRegFile.sv ====
// Widened integer register file, 8 read ports and 4 write ports
// Reads are combinational and write-first; x0 is hard zero
// Same-cycle writes to one register resolve to the highest lane

`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_consts.svh"

module widenedRegFile (
  input  logic                                   clk,
  input  logic                                   reset,
  input  vliwPkg::regAddr_t [2*`VLIW_LANES-1:0]  rdAddr,
  input  logic [`VLIW_LANES-1:0]                 weValid,
  input  vliwPkg::regAddr_t [`VLIW_LANES-1:0]    weAddr,
  input  vliwPkg::word_t [`VLIW_LANES-1:0]       weData,
  output vliwPkg::word_t [2*`VLIW_LANES-1:0]     rdData
);

  vliwPkg::word_t regs [`NUM_REGS];

  //////////////////////////////////////////////////////////////////////
  // Write ports
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < `NUM_REGS; r++) begin
        regs[r] <= '0;  // Architectural state starts cleared
      end
    end else begin
      // Ascending order, last NBA wins so lane 3 beats lane 0
      for (int l = 0; l < `VLIW_LANES; l++) begin
        if (weValid[l] && weAddr[l] != '0) begin
          regs[weAddr[l]] <= weData[l];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports with write-first bypass
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int p = 0; p < 2*`VLIW_LANES; p++) begin
      rdData[p] = regs[rdAddr[p]];
      for (int l = 0; l < `VLIW_LANES; l++) begin
        if (weValid[l] && weAddr[l] == rdAddr[p]) begin
          rdData[p] = weData[l];  // Same priority as the write side
        end
      end
      if (rdAddr[p] == '0) begin
        rdData[p] = '0;  // x0 never bypassed
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bundleDecode.sv ====
// Bundle decode, one cycle from sampled bundle to E-stage registers
// Register reads happen combinationally in the decode cycle
// No intra-bundle dependencies; every lane sees the pre-bundle register state

`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_consts.svh"

module bundleDecode (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      bundleValid,
  input  logic [`VLIW_LANES-1:0]                    laneValid,
  input  logic [`VLIW_LANES-1:0][`INSTR_W-1:0]      instr,
  input  vliwPkg::word_t [2*`VLIW_LANES-1:0]        rdData,
  output vliwPkg::regAddr_t [2*`VLIW_LANES-1:0]     rdAddr,
  output logic [`VLIW_LANES-1:0]                    exValid,
  output vliwPkg::aluOp_t [`VLIW_LANES-1:0]         exAluOp,
  output vliwPkg::regAddr_t [`VLIW_LANES-1:0]       exRd,
  output vliwPkg::regAddr_t [`VLIW_LANES-1:0]       exRs1,
  output vliwPkg::regAddr_t [`VLIW_LANES-1:0]       exRs2,
  output vliwPkg::word_t [`VLIW_LANES-1:0]          exSrcA,
  output vliwPkg::word_t [`VLIW_LANES-1:0]          exSrcB,
  output logic [`VLIW_LANES-1:0]                    exUseImm
);

  logic [`VLIW_LANES-1:0]              legalD;   // Opcode is one of opcode_t
  logic [`VLIW_LANES-1:0]              useImmD;  // B comes from the immediate
  vliwPkg::aluOp_t [`VLIW_LANES-1:0]   aluOpD;
  vliwPkg::word_t [`VLIW_LANES-1:0]    immD;

  //////////////////////////////////////////////////////////////////////
  // Field extraction and ALU op mapping
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `VLIW_LANES; i++) begin
      // Port pair 2i/2i+1 belongs to lane i
      rdAddr[2*i]   = instr[i][19:15];  // rs1
      rdAddr[2*i+1] = instr[i][24:20];  // rs2

      legalD[i]  = 1'b1;
      useImmD[i] = 1'b1;
      immD[i]    = {{(`XLEN-12){instr[i][31]}}, instr[i][31:20]};  // Sign-extended I imm

      case (instr[i][6:0])
        vliwPkg::OpReg: useImmD[i] = 1'b0;
        vliwPkg::OpImm: useImmD[i] = 1'b1;
        vliwPkg::OpLui: immD[i] = {instr[i][31:12], 12'b0};  // U imm
        default:        legalD[i] = 1'b0;  // Lane drops out
      endcase

      // funct3 picks the family, bit 30 picks SUB and SRA
      case (instr[i][14:12])
        3'b000: begin
          if (instr[i][6:0] == vliwPkg::OpReg && instr[i][30]) begin
            aluOpD[i] = vliwPkg::AluSub;
          end else begin
            aluOpD[i] = vliwPkg::AluAdd;  // ADDI never subtracts
          end
        end
        3'b001: aluOpD[i] = vliwPkg::AluSll;
        3'b010: aluOpD[i] = vliwPkg::AluSlt;
        3'b011: aluOpD[i] = vliwPkg::AluSltu;
        3'b100: aluOpD[i] = vliwPkg::AluXor;
        3'b101: begin
          if (instr[i][30]) begin
            aluOpD[i] = vliwPkg::AluSra;  // Same bit for SRAI
          end else begin
            aluOpD[i] = vliwPkg::AluSrl;
          end
        end
        3'b110: aluOpD[i] = vliwPkg::AluOr;
        default: aluOpD[i] = vliwPkg::AluAnd;
      endcase

      // LUI ignores funct3 entirely
      if (instr[i][6:0] == vliwPkg::OpLui) begin
        aluOpD[i] = vliwPkg::AluPassB;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // E-stage registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < `VLIW_LANES; i++) begin
      if (reset) begin
        exValid[i] <= 1'b0;
      end else begin
        // rd of x0 means no writeback at all
        exValid[i] <= bundleValid & laneValid[i] & legalD[i] & (instr[i][11:7] != '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `VLIW_LANES; i++) begin
      exAluOp[i]  <= aluOpD[i];
      exRd[i]     <= instr[i][11:7];
      exRs1[i]    <= instr[i][19:15];
      exRs2[i]    <= instr[i][24:20];
      exSrcA[i]   <= rdData[2*i];
      exSrcB[i]   <= useImmD[i] ? immD[i] : rdData[2*i+1];  // Imm replaces rs2 value
      exUseImm[i] <= useImmD[i];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vliwPkg.sv ====
// Shared types for the VLIW core
// Opcode list covers only the kept RV32I groups; anything else is illegal

`default_nettype none

`include "vliwCore_consts.svh"

package vliwPkg;

  typedef logic [`XLEN-1:0]       word_t;     // One data word
  typedef logic [`REG_ADDR_W-1:0] regAddr_t;  // Register index

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OpReg = 7'b0110011,   // R-type ALU
    OpImm = 7'b0010011,   // I-type ALU
    OpLui = 7'b0110111    // Upper immediate
  } opcode_t;

  // ALU function per lane
  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd,
    AluPassB   // LUI result is the immediate itself
  } aluOp_t;

endpackage

`default_nettype wire

// ==== hdl/vliwCore_consts.svh ====
// Core-wide sizing for the four-lane VLIW integer core
// Widths are fixed for RV32I and are not meant to be overridden per build
// Include after the package or stand-alone; the guard prevents redefinition

`ifndef VLIWCORE_CONSTS_SVH
`define VLIWCORE_CONSTS_SVH

// Issue width of one bundle
`define VLIW_LANES 4

// Data word width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Raw instruction width per lane
`define INSTR_W 32

// Architectural integer registers
`define NUM_REGS 32

`endif
